// ==== Makefile ====
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the bitsync testbench with Verilator"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f tb.f --top-module bitsyncTb -Mdir obj_dir -o bitsyncSim
	./obj_dir/bitsyncSim | tee sim.log
	grep -q "Simulation PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== common/bitsyncPkg.sv ====
//****************************************
// Bitsync shared definitions
// Widths, modes, FSM encodings and the
// structs passed between loop blocks
//****************************************

`default_nettype none

package bitsyncPkg;

    // Datapath widths
    localparam int sampleWidth = 18;
    localparam int errorWidth = 12;
    localparam int freqWidth = 32;
    localparam int accumWidth = 22;
    localparam int lockWidth = 16;
    localparam int shiftWidth = 5;

    // Transitions per averaging window, minus one
    localparam int avgLength = 15;

    typedef logic signed [sampleWidth-1:0] sampleT;

    typedef enum logic [4:0] {
        BPSK = 5'd0,
        QPSK = 5'd1,
        OQPSK = 5'd2,
        SOQPSK = 5'd3
    } demodModeT;

    // Two samples per symbol
    typedef enum logic {
        onTime = 1'b0,
        offTime = 1'b1
    } tedStateT;

    typedef enum logic [1:0] {
        average = 2'b00,
        test = 2'b01,
        slip0 = 2'b11,
        slip1 = 2'b10
    } slipStateT;

    typedef struct packed {
        sampleT i;
        sampleT q;
    } iqSampleT;

    typedef struct packed {
        demodModeT demodMode;
        logic oqpskIThenQ;
        logic useSummer;
        logic [freqWidth-1:0] nominalFreq;
        logic [shiftWidth-1:0] propShift;
        logic [shiftWidth-1:0] intShift;
        logic [lockWidth-1:0] lockCount;
    } bitsyncConfigT;

    typedef struct packed {
        logic signed [sampleWidth:0] timingError;
        sampleT slipError;
        logic transition;
        logic errorValid;
    } tedResultT;

endpackage

`default_nettype wire

// ==== rtl/bitsync.sv ====
//****************************************
// Bitsync top level
// Symbol timing recovery loop for the PSK
// and QPSK demodulator
//****************************************

`timescale 1ns/10ps
`default_nettype none

module bitsync import bitsyncPkg::*; (
    input  wire logic          clk,
    input  wire logic          reset,
    input  wire logic          sym2xEn,
    input  wire iqSampleT      iqIn,
    input  wire bitsyncConfigT cfg,
    output sampleT             symDataI,
    output sampleT             symDataQ,
    output logic               bitDataI,
    output logic               bitDataQ,
    output logic               symEn,
    output logic               sym2xEnOut,
    output sampleT             offsetError,
    output logic               offsetErrorEn,
    output sampleT             bsError,
    output logic               bsErrorEn,
    output logic [freqWidth-1:0] sampleFreq,
    output logic               bitsyncLock,
    output logic [lockWidth-1:0] lockCounter
);

    iqSampleT iqMf;
    tedResultT ted;
    logic slip;
    logic loopEn;
    logic signed [errorWidth-1:0] loopError;
    sampleT roundedError;

    sampleFilter sampleFilter_i (
        .clk     (clk),
        .sym2xEn (sym2xEn),
        .iqIn    (iqIn),
        .cfg     (cfg),
        .iqMf    (iqMf)
    );

    timingErrorDetector timingErrorDetector_i (
        .clk           (clk),
        .reset         (reset),
        .sym2xEn       (sym2xEn),
        .iqMf          (iqMf),
        .demodMode     (cfg.demodMode),
        .slip          (slip),
        .ted           (ted),
        .offsetError   (offsetError),
        .offsetErrorEn (offsetErrorEn),
        .symEn         (symEn),
        .symDataI      (symDataI),
        .symDataQ      (symDataQ),
        .bitDataI      (bitDataI),
        .bitDataQ      (bitDataQ)
    );

    lockMonitor lockMonitor_i (
        .clk         (clk),
        .reset       (reset),
        .sym2xEn     (sym2xEn),
        .ted         (ted),
        .lockCount   (cfg.lockCount),
        .slip        (slip),
        .bitsyncLock (bitsyncLock),
        .lockCounter (lockCounter)
    );

    //****************************************
    // Loop error rounding
    //****************************************
    assign loopEn = sym2xEn && ted.errorValid;
    assign loopError = ted.timingError[sampleWidth:sampleWidth-errorWidth+1] +
                       errorWidth'(ted.timingError[sampleWidth-errorWidth]);
    assign roundedError = ted.timingError[sampleWidth:1] + sampleWidth'(ted.timingError[0]);

    loopFilter loopFilter_i (
        .clk         (clk),
        .reset       (reset),
        .loopEn      (loopEn),
        .error       (loopError),
        .nominalFreq (cfg.nominalFreq),
        .propShift   (cfg.propShift),
        .intShift    (cfg.intShift),
        .sampleFreq  (sampleFreq)
    );

    // Error output for monitoring
    always_ff @(posedge clk) begin
        bsError <= roundedError;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            bsErrorEn <= 1'b0;
        end else begin
            bsErrorEn <= loopEn;
        end
    end

    assign sym2xEnOut = sym2xEn;

endmodule

`default_nettype wire

// ==== rtl/loopFilter.sv ====
//****************************************
// Bitsync loop filter
// Proportional plus saturating integral
// path onto the nominal sample frequency
//****************************************

`timescale 1ns/10ps
`default_nettype none

module loopFilter import bitsyncPkg::*; (
    input  wire logic                         clk,
    input  wire logic                         reset,
    input  wire logic                         loopEn,
    input  wire logic signed [errorWidth-1:0] error,
    input  wire logic [freqWidth-1:0]         nominalFreq,
    input  wire logic [shiftWidth-1:0]        propShift,
    input  wire logic [shiftWidth-1:0]        intShift,
    output logic [freqWidth-1:0]              sampleFreq
);

    localparam logic signed [freqWidth-1:0] maxFreq = {1'b0, {(freqWidth-1){1'b1}}};
    localparam logic signed [freqWidth-1:0] minFreq = {1'b1, {(freqWidth-1){1'b0}}};

    logic signed [freqWidth-1:0] errorExt;
    logic signed [freqWidth-1:0] propTerm, intTerm;
    logic signed [freqWidth-1:0] propReg, integrator;
    logic signed [freqWidth:0] intSum;

    assign errorExt = freqWidth'(error);
    assign propTerm = errorExt <<< propShift;
    assign intTerm = errorExt <<< intShift;
    assign intSum = {integrator[freqWidth-1], integrator} + {intTerm[freqWidth-1], intTerm};

    always_ff @(posedge clk) begin
        if (reset) begin
            propReg <= '0;
            integrator <= '0;
        end else if (loopEn) begin
            propReg <= propTerm;
            // Clamp on overflow of the top bit
            if (intSum[freqWidth] != intSum[freqWidth-1]) begin
                integrator <= intSum[freqWidth] ? minFreq : maxFreq;
            end else begin
                integrator <= intSum[freqWidth-1:0];
            end
        end
    end

    assign sampleFreq = nominalFreq + propReg + integrator;

endmodule

`default_nettype wire

// ==== rtl/sampleFilter.sv ====
//****************************************
// Bitsync front filter
// Optional two-sample sum on I and Q, then
// half-symbol deskew for offset QPSK
//****************************************

`timescale 1ns/10ps
`default_nettype none

module sampleFilter import bitsyncPkg::*; (
    input  wire logic          clk,
    input  wire logic          sym2xEn,
    input  wire iqSampleT      iqIn,
    input  wire bitsyncConfigT cfg,
    output iqSampleT           iqMf
);

    sampleT iDelay, qDelay;
    sampleT iFiltered, qFiltered;
    sampleT iSymDelay, qSymDelay;
    logic signed [sampleWidth:0] iSum, qSum;

    // One extra bit so the sum cannot wrap
    assign iSum = {iDelay[sampleWidth-1], iDelay} + {iqIn.i[sampleWidth-1], iqIn.i};
    assign qSum = {qDelay[sampleWidth-1], qDelay} + {iqIn.q[sampleWidth-1], iqIn.q};

    //****************************************
    // Two sample sum
    //****************************************
    always_ff @(posedge clk) begin
        if (sym2xEn) begin
            iDelay <= iqIn.i;
            qDelay <= iqIn.q;
            if (cfg.useSummer) begin
                iFiltered <= iSum[sampleWidth:1];
                qFiltered <= qSum[sampleWidth:1];
            end else begin
                iFiltered <= iDelay;
                qFiltered <= qDelay;
            end
        end
    end

    //****************************************
    // Symbol offset deskew
    //****************************************
    always_ff @(posedge clk) begin
        if (sym2xEn) begin
            iSymDelay <= iFiltered;
            qSymDelay <= qFiltered;
            case (cfg.demodMode)
                BPSK: begin
                    // Single rail, Q follows I
                    iqMf.i <= iFiltered;
                    iqMf.q <= iFiltered;
                end
                OQPSK: begin
                    if (cfg.oqpskIThenQ) begin
                        iqMf.i <= iSymDelay;
                        iqMf.q <= qFiltered;
                    end else begin
                        iqMf.i <= iFiltered;
                        iqMf.q <= qSymDelay;
                    end
                end
                SOQPSK: begin
                    iqMf.i <= iFiltered;
                    iqMf.q <= qSymDelay;
                end
                default: begin
                    iqMf.i <= iFiltered;
                    iqMf.q <= qFiltered;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== tb.f ====
common/bitsyncPkg.sv
rtl/sampleFilter.sv
ted/timingErrorDetector.sv
ted/lockMonitor.sv
rtl/loopFilter.sv
rtl/bitsync.sv
tb/bitsyncChecks.sv
tb/bitsyncTb.sv

// ==== tb/bitsyncChecks.sv ====
//****************************************
// Bitsync checker
// Clocked assertions on the DUT outputs
// and the error counter
//****************************************

`timescale 1ns/10ps
`default_nettype none

module bitsyncChecks import bitsyncPkg::*; (
    input  wire logic                 clk,
    input  wire logic                 reset,
    input  wire logic                 sym2xEn,
    input  wire logic                 sym2xEnOut,
    input  wire logic                 symEn,
    input  wire logic                 bitDataI,
    input  wire logic                 bitDataQ,
    input  wire sampleT               offsetError,
    input  wire logic                 offsetErrorEn,
    input  wire sampleT               bsError,
    input  wire logic                 bsErrorEn,
    input  wire logic [freqWidth-1:0] sampleFreq,
    input  wire logic                 bitsyncLock,
    input  wire logic [lockWidth-1:0] lockCounter,
    input  wire logic [lockWidth-1:0] lockCount,
    input  wire logic [freqWidth-1:0] nominalFreq,
    input  wire logic                 checkTiming,
    input  wire logic                 checkConstant,
    input  wire logic                 checkAlternate,
    input  wire logic                 checkOffset,
    input  wire logic                 checkError,
    input  wire sampleT               expectedOffset,
    input  wire sampleT               expectedError,
    output int                        errorCount
);

    logic resetQ;
    logic symPhase;
    logic lastBitI, lastBitQ;
    logic [lockWidth-1:0] lastCounter;
    logic lastLock;
    logic [lockWidth-1:0] expectedCounter;
    logic expectedLock;

    initial begin
        errorCount = 0;
    end

    task automatic reportMismatch(input string name, input logic [31:0] got,
                                  input logic [31:0] expected);
        $display("CHECK FAILED %s got 0x%h expected 0x%h at %0t", name, got, expected, $time);
        errorCount = errorCount + 1;
    endtask

    always @(posedge clk) begin
        resetQ <= reset;

        //****************************************
        // State right after reset
        //****************************************
        if (resetQ) begin
            assert (bitsyncLock == 1'b0)
                else reportMismatch("bitsyncLock", 32'(bitsyncLock), 32'h0);
            assert (lockCounter == '0)
                else reportMismatch("lockCounter", 32'(lockCounter), 32'h0);
            assert (bsErrorEn == 1'b0)
                else reportMismatch("bsErrorEn", 32'(bsErrorEn), 32'h0);
            assert (sampleFreq == nominalFreq)
                else reportMismatch("sampleFreq", sampleFreq, nominalFreq);
        end

        // Half symbol strobe passes straight out
        if (checkTiming) begin
            assert (sym2xEnOut == sym2xEn)
                else reportMismatch("sym2xEnOut", 32'(sym2xEnOut), 32'(sym2xEn));
        end

        // symEn on every second strobe
        if (reset) begin
            symPhase <= 1'b1;
        end else if (sym2xEn) begin
            if (checkTiming) begin
                assert (symEn == symPhase)
                    else reportMismatch("symEn", 32'(symEn), 32'(symPhase));
            end
            symPhase <= ~symPhase;
        end

        if (symEn) begin
            if (checkAlternate) begin
                assert (bitDataI != lastBitI)
                    else reportMismatch("bitDataI", 32'(bitDataI), 32'(~lastBitI));
                assert (bitDataQ != lastBitQ)
                    else reportMismatch("bitDataQ", 32'(bitDataQ), 32'(~lastBitQ));
            end
            lastBitI <= bitDataI;
            lastBitQ <= bitDataQ;
        end

        //****************************************
        // Lock counter steps once per test
        //****************************************
        if (checkAlternate && (lockCounter != lastCounter || bitsyncLock != lastLock)) begin
            expectedCounter = (lastCounter == lockCount) ? '0 : lastCounter + 1'b1;
            expectedLock = lastLock || (lastCounter == lockCount);
            assert (lockCounter == expectedCounter)
                else reportMismatch("lockCounter", 32'(lockCounter), 32'(expectedCounter));
            assert (bitsyncLock == expectedLock)
                else reportMismatch("bitsyncLock", 32'(bitsyncLock), 32'(expectedLock));
        end
        lastCounter <= lockCounter;
        lastLock <= bitsyncLock;

        //****************************************
        // No transitions on constant input
        //****************************************
        if (checkConstant) begin
            assert (bitDataI == 1'b0)
                else reportMismatch("bitDataI", 32'(bitDataI), 32'h0);
            assert (bitDataQ == 1'b1)
                else reportMismatch("bitDataQ", 32'(bitDataQ), 32'h1);
            assert (offsetError == '0)
                else reportMismatch("offsetError", 32'(offsetError), 32'h0);
            assert (sampleFreq == nominalFreq)
                else reportMismatch("sampleFreq", sampleFreq, nominalFreq);
        end

        if (checkOffset && offsetErrorEn) begin
            assert (offsetError == expectedOffset)
                else reportMismatch("offsetError", 32'(offsetError), 32'(expectedOffset));
        end

        if (checkError && bsErrorEn) begin
            assert (bsError == expectedError)
                else reportMismatch("bsError", 32'(bsError), 32'(expectedError));
        end
    end

endmodule

`default_nettype wire

// ==== tb/bitsyncTb.sv ====
//****************************************
// Bitsync testbench
// Strobed stimulus, DUT, checker, watchdog
// and the closing report
//****************************************

`timescale 1ns/10ps
`default_nettype none

module bitsyncTb import bitsyncPkg::*; ();

    localparam int constLen = 60;
    localparam int lockLen = 300;
    localparam int offsetLen = 100;
    localparam int lateLen = 100;
    localparam int skewLen = 40;
    localparam int numTests = 6;
    localparam int settle = 12;
    localparam int totalStrobes = numTests * 8 + constLen + lockLen + offsetLen +
                                  lateLen + 2 * skewLen;
    localparam int totalCycles = totalStrobes * 4 + numTests * 2 + 4;
    localparam int timeoutNs = totalCycles * 8 * 3 / 2;

    logic clk, reset, sym2xEn;
    iqSampleT iqIn;
    bitsyncConfigT cfg;

    sampleT symDataI, symDataQ, offsetError, bsError;
    logic bitDataI, bitDataQ, symEn, sym2xEnOut, offsetErrorEn, bsErrorEn;
    logic [freqWidth-1:0] sampleFreq;
    logic bitsyncLock;
    logic [lockWidth-1:0] lockCounter;

    logic checkTiming, checkConstant, checkAlternate, checkOffset, checkError;
    sampleT expectedOffset, expectedError;
    int checkErrors;
    int tbErrors;
    integer seed;

    bitsync bitsync_i (.*);

    bitsyncChecks checks_i (
        .nominalFreq (cfg.nominalFreq),
        .lockCount   (cfg.lockCount),
        .errorCount  (checkErrors),
        .*
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Watchdog
    initial begin
        #(timeoutNs);
        $display("Watchdog timeout, the tests did not finish in time");
        $display("Simulation FAILED");
        $finish;
    end

    task automatic reportTb(input string name, input logic [31:0] got,
                            input logic [31:0] expected);
        $display("CHECK FAILED %s got 0x%h expected 0x%h at %0t", name, got, expected, $time);
        tbErrors = tbErrors + 1;
    endtask

    // One half symbol, four clocks long
    task automatic driveStrobe(input sampleT iVal, input sampleT qVal);
        iqIn.i = iVal;
        iqIn.q = qVal;
        sym2xEn = 1'b1;
        @(posedge clk);
        #1;
        sym2xEn = 1'b0;
        repeat (3) begin
            @(posedge clk);
            #1;
        end
    endtask

    // Flush the front filter, then reset for 10 clocks
    task automatic resetDut(input sampleT iVal, input sampleT qVal);
        checkTiming = 1'b0;
        checkConstant = 1'b0;
        checkAlternate = 1'b0;
        checkOffset = 1'b0;
        checkError = 1'b0;
        repeat (6) driveStrobe(iVal, qVal);
        reset = 1'b1;
        repeat (2) driveStrobe(iVal, qVal);
        @(posedge clk);
        #1;
        @(posedge clk);
        #1;
        reset = 1'b0;
        checkTiming = 1'b1;
    endtask

    // Odd half symbols carry alternating +amp and -amp, even ones zero
    function automatic sampleT symbolValue(input int m, input sampleT amp);
        if (m % 2 == 0) begin
            return '0;
        end
        return ((m >> 1) % 2 == 0) ? amp : -amp;
    endfunction

    task automatic runAlternating(input int len, input sampleT amp, input sampleT dc,
                                  input sampleT late);
        sampleT value;
        for (int m = 0; m < len; m++) begin
            value = symbolValue(m, amp) + dc;
            if (m % 2 == 0 && m >= 2) begin
                value = value + (((m >> 1) % 2 == 1) ? late : -late);
            end
            if (m == settle) begin
                checkAlternate = 1'b1;
                checkOffset = (dc != '0);
                checkError = (dc == '0);
            end
            driveStrobe(value, value);
        end
    endtask

    // Lags found from index-coded samples
    task automatic runSkew(input int expectedSkew);
        int lagI, lagQ;
        for (int m = 0; m < skewLen; m++) begin
            driveStrobe(sampleT'(m), sampleT'(m + 4096));
            lagI = m - int'(symDataI);
            lagQ = m + 4096 - int'(symDataQ);
            if (m >= settle) begin
                assert (lagQ - lagI == expectedSkew)
                    else reportTb("symDataQ lag", 32'(lagQ - lagI), 32'(expectedSkew));
            end
        end
    endtask

    initial begin
        sampleT amp;
        sampleT late;
        seed = 32'h29a4;
        tbErrors = 0;
        reset = 1'b0;
        sym2xEn = 1'b0;
        iqIn = '0;
        checkTiming = 1'b0;
        checkConstant = 1'b0;
        checkAlternate = 1'b0;
        checkOffset = 1'b0;
        checkError = 1'b0;
        expectedOffset = '0;
        expectedError = '0;
        cfg.demodMode = QPSK;
        cfg.oqpskIThenQ = 1'b0;
        cfg.useSummer = 1'b0;
        cfg.nominalFreq = 32'h2000_0000;
        cfg.propShift = 5'd4;
        cfg.intShift = 5'd0;
        cfg.lockCount = 16'd3;
        @(posedge clk);
        #1;

        //****************************************
        // Reset state and constant QPSK input
        //****************************************
        amp = sampleT'(16384 + ($random(seed) & 16'h3fff));
        resetDut(amp, -amp);
        for (int m = 0; m < constLen; m++) begin
            if (m == settle) begin
                checkConstant = 1'b1;
                checkError = 1'b1;
            end
            driveStrobe(amp, -amp);
        end

        // Well-timed BPSK symbols reach lock
        cfg.demodMode = BPSK;
        amp = sampleT'(16384 + ($random(seed) & 16'h3fff));
        expectedError = '0;
        resetDut('0, '0);
        runAlternating(lockLen, amp, '0, '0);
        assert (bitsyncLock == 1'b1) else reportTb("bitsyncLock", 32'(bitsyncLock), 32'h1);

        // DC offset on every sample
        amp = sampleT'(16384 + ($random(seed) & 16'h3fff));
        expectedOffset = sampleT'(-1234);
        resetDut(expectedOffset, expectedOffset);
        runAlternating(offsetLen, amp, expectedOffset, '0);

        //****************************************
        // Late sampling drives the frequency up
        //****************************************
        amp = sampleT'(16384 + ($random(seed) & 16'h3fff));
        late = sampleT'(4096);
        expectedError = late;
        resetDut('0, '0);
        runAlternating(lateLen, amp, '0, late);
        assert (sampleFreq > cfg.nominalFreq)
            else reportTb("sampleFreq", sampleFreq, cfg.nominalFreq);

        // Offset QPSK deskew, then plain QPSK
        cfg.demodMode = OQPSK;
        resetDut('0, '0);
        runSkew(1);
        cfg.demodMode = QPSK;
        resetDut('0, '0);
        runSkew(0);

        $display("Errors: checker %0d, testbench %0d", checkErrors, tbErrors);
        if (checkErrors + tbErrors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== ted/lockMonitor.sv ====
//****************************************
// Bitsync lock monitor
// Averages timing and slip error magnitudes,
// slips the TED on false lock and runs the
// up/down lock counter
//****************************************

`timescale 1ns/10ps
`default_nettype none

module lockMonitor import bitsyncPkg::*; (
    input  wire logic                 clk,
    input  wire logic                 reset,
    input  wire logic                 sym2xEn,
    input  wire tedResultT            ted,
    input  wire logic [lockWidth-1:0] lockCount,
    output logic                      slip,
    output logic                      bitsyncLock,
    output logic [lockWidth-1:0]      lockCounter
);

    slipStateT slipState;
    logic [3:0] avgCount;
    logic [accumWidth-1:0] avgError, avgSlipError;

    sampleT meanError;
    logic [sampleWidth-1:0] absError, absSlipError;
    logic slipNeeded;
    logic errorHigh;

    // Mean of the I and Q rail errors
    assign meanError = ted.timingError[sampleWidth:1];
    assign absError = meanError[sampleWidth-1] ? -meanError : meanError;
    assign absSlipError = ted.slipError[sampleWidth-1] ? -ted.slipError : ted.slipError;

    // Slip error under half the timing error
    assign slipNeeded = avgSlipError < {1'b0, avgError[accumWidth-1:1]};
    assign errorHigh = avgError[accumWidth-1:accumWidth-8] >
                       {1'b0, avgSlipError[accumWidth-1:accumWidth-7]};

    //****************************************
    // Averaging and slip FSM
    //****************************************
    always_ff @(posedge clk) begin
        if (reset) begin
            slipState <= average;
            avgCount <= 4'(avgLength);
            avgError <= '0;
            avgSlipError <= '0;
            slip <= 1'b0;
            bitsyncLock <= 1'b0;
            lockCounter <= '0;
        end else if (sym2xEn) begin
            case (slipState)
                average: begin
                    slip <= 1'b0;
                    if (ted.errorValid && ted.transition) begin
                        avgError <= avgError + accumWidth'(absError);
                        avgSlipError <= avgSlipError + accumWidth'(absSlipError);
                        if (avgCount == 4'd0) begin
                            slipState <= test;
                        end else begin
                            avgCount <= avgCount - 4'd1;
                        end
                    end
                end
                test: begin
                    avgCount <= 4'(avgLength);
                    avgError <= '0;
                    avgSlipError <= '0;
                    if (slipNeeded) begin
                        slipState <= slip0;
                        slip <= 1'b1;
                    end else begin
                        slipState <= average;
                    end
                    // Lock counter moves once per test
                    if (errorHigh) begin
                        if (lockCounter == ~lockCount) begin
                            bitsyncLock <= 1'b0;
                            lockCounter <= '0;
                        end else begin
                            lockCounter <= lockCounter - 1'b1;
                        end
                    end else begin
                        if (lockCounter == lockCount) begin
                            bitsyncLock <= 1'b1;
                            lockCounter <= '0;
                        end else begin
                            lockCounter <= lockCounter + 1'b1;
                        end
                    end
                end
                slip0: begin
                    slip <= 1'b0;
                    slipState <= slip1;
                end
                slip1: begin
                    slip <= 1'b0;
                    slipState <= average;
                end
                default: begin
                    slipState <= average;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== ted/timingErrorDetector.sv ====
//****************************************
// Bitsync timing error detector
// Early, off-time, late detector at two
// samples per symbol with DC offset error,
// slip control and hard bit decisions
//****************************************

`timescale 1ns/10ps
`default_nettype none

module timingErrorDetector import bitsyncPkg::*; (
    input  wire logic      clk,
    input  wire logic      reset,
    input  wire logic      sym2xEn,
    input  wire iqSampleT  iqMf,
    input  wire demodModeT demodMode,
    input  wire logic      slip,
    output tedResultT      ted,
    output sampleT         offsetError,
    output logic           offsetErrorEn,
    output logic           symEn,
    output sampleT         symDataI,
    output sampleT         symDataQ,
    output logic           bitDataI,
    output logic           bitDataQ
);

    tedStateT tedState;
    logic slipped;
    logic dualRail;

    // Index 0 is late, 1 off-time, 2 early
    sampleT bbI [0:2];
    sampleT bbQ [0:2];

    sampleT errorI, errorQ, slipError;
    logic signed [sampleWidth:0] dcError;
    logic transition;
    logic transitionI, transitionQ;

    assign dualRail = (demodMode != BPSK);

    //****************************************
    // Baseband shift register
    //****************************************
    always_ff @(posedge clk) begin
        if (sym2xEn) begin
            bbI[0] <= iqMf.i;
            bbQ[0] <= dualRail ? iqMf.q : iqMf.i;
            bbI[1] <= bbI[0];
            bbI[2] <= bbI[1];
            bbQ[1] <= bbQ[0];
            bbQ[2] <= bbQ[1];
        end
    end

    // Sign change between early and late
    assign transitionI = bbI[2][sampleWidth-1] != bbI[0][sampleWidth-1];
    assign transitionQ = bbQ[2][sampleWidth-1] != bbQ[0][sampleWidth-1];

    //****************************************
    // On/off-time state and error terms
    //****************************************
    always_ff @(posedge clk) begin
        if (reset) begin
            tedState <= onTime;
            slipped <= 1'b0;
            transition <= 1'b0;
            errorI <= '0;
            errorQ <= '0;
            slipError <= '0;
            dcError <= '0;
        end else if (sym2xEn) begin
            case (tedState)
                onTime: begin
                    // A slip holds on-time for one extra strobe
                    if (slip && !slipped) begin
                        tedState <= onTime;
                    end else begin
                        tedState <= offTime;
                    end
                    slipped <= slip;
                end
                offTime: begin
                    tedState <= onTime;
                    if (transitionI) begin
                        transition <= 1'b1;
                        dcError <= (sampleWidth+1)'(bbI[2]) + (sampleWidth+1)'(bbI[0]);
                        if (bbI[2][sampleWidth-1]) begin
                            // Low to high
                            errorI <= -bbI[1];
                            slipError <= bbI[0];
                        end else begin
                            errorI <= bbI[1];
                            slipError <= bbI[2];
                        end
                    end else begin
                        transition <= 1'b0;
                        dcError <= '0;
                        errorI <= '0;
                    end
                    if (transitionQ) begin
                        if (bbQ[2][sampleWidth-1]) begin
                            errorQ <= -bbQ[1];
                        end else begin
                            errorQ <= bbQ[1];
                        end
                    end else begin
                        errorQ <= '0;
                    end
                end
                default: begin
                    tedState <= onTime;
                end
            endcase
        end
    end

    always_comb begin
        ted.timingError = (sampleWidth+1)'(errorI) + (sampleWidth+1)'(errorQ);
        ted.slipError = slipError;
        ted.transition = transition;
        ted.errorValid = (tedState == onTime);
    end

    // Half of early plus late
    assign offsetError = dcError[sampleWidth:1];
    assign offsetErrorEn = (tedState == offTime);
    assign symEn = sym2xEn && (tedState == onTime);

    //****************************************
    // Recovered symbols and bits
    //****************************************
    always_ff @(posedge clk) begin
        if (sym2xEn) begin
            symDataI <= bbI[0];
            symDataQ <= bbQ[0];
        end
        if (symEn) begin
            bitDataI <= bbI[1][sampleWidth-1];
            bitDataQ <= bbQ[1][sampleWidth-1];
        end
    end

endmodule

`default_nettype wire
